// ==== sim.f ====
+incdir+design
design/mem_types_pkg.sv
design/bus_pkg.sv
design/line_cache.sv
design/bus_arbiter.sv
design/mem_subsys_top.sv
dv/mem_responder.sv
dv/tb_mem_subsys.sv

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
    import mem_types_pkg::*;
    import bus_pkg::*;
();

    localparam int    clk_period = 40;
    localparam int    n_entries  = 22;
    localparam data_t mem_base   = 32'hC0DE_0000;
    localparam logic  sel_inst   = 1'b0;
    localparam logic  sel_data   = 1'b1;

    logic  aclk;
    logic  rst_n;
    logic  inst_req, inst_we, inst_ack;
    addr_t inst_addr;
    data_t inst_wdata, inst_rdata;
    logic  data_req, data_we, data_ack;
    addr_t data_addr;
    data_t data_wdata, data_rdata;
    logic  mem_req, mem_we, mem_ack;
    addr_t mem_addr;
    data_t mem_wdata, mem_rdata;
    int    rd_count, wr_count;
    addr_t last_wr_addr;
    data_t last_wr_data;

    // stimulus and expected values, one row per operation
    logic  tbl_port  [n_entries];
    logic  tbl_we    [n_entries];
    addr_t tbl_addr  [n_entries];
    data_t tbl_wdata [n_entries];
    data_t tbl_rdata [n_entries];
    int    tbl_rd    [n_entries];
    int    tbl_wr    [n_entries];
    logic  tbl_pair  [n_entries];   // issued together with the next row
    int    n_loaded;
    int    n_checks;
    int    n_errors;

    mem_subsys_top dut0 (
        .aclk(aclk), .rst_n(rst_n),
        .inst_req(inst_req), .inst_we(inst_we), .inst_addr(inst_addr),
        .inst_wdata(inst_wdata), .inst_ack(inst_ack), .inst_rdata(inst_rdata),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_ack(data_ack), .data_rdata(data_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    mem_responder #(.init_base(mem_base), .seed(39550)) mem0 (
        .aclk(aclk), .rst_n(rst_n),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .rd_count(rd_count), .wr_count(wr_count),
        .last_wr_addr(last_wr_addr), .last_wr_data(last_wr_data)
    );

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    // memory content before any write
    function automatic data_t init_word(input addr_t a);
        return mem_base + a[9:2];
    endfunction

    task automatic check_data(input string what, input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic add_entry(input logic port, input logic we, input addr_t addr,
                             input data_t wdata, input data_t rdata,
                             input int rd, input int wr, input logic pair);
        tbl_port[n_loaded]  = port;
        tbl_we[n_loaded]    = we;
        tbl_addr[n_loaded]  = addr;
        tbl_wdata[n_loaded] = wdata;
        tbl_rdata[n_loaded] = rdata;
        tbl_rd[n_loaded]    = rd;
        tbl_wr[n_loaded]    = wr;
        tbl_pair[n_loaded]  = pair;
        n_loaded++;
    endtask

    task automatic load_table();
        n_loaded = 0;
        // miss then hit on both sides
        add_entry(sel_data, 1'b0, 32'h044, '0, init_word(32'h044), 1, 0, 1'b0);
        add_entry(sel_data, 1'b0, 32'h044, '0, init_word(32'h044), 0, 0, 1'b0);
        add_entry(sel_inst, 1'b0, 32'h108, '0, init_word(32'h108), 1, 0, 1'b0);
        add_entry(sel_inst, 1'b0, 32'h108, '0, init_word(32'h108), 0, 0, 1'b0);
        // write hit updates the line, write miss does not allocate
        add_entry(sel_data, 1'b1, 32'h044, 32'h1234_5678, '0, 0, 1, 1'b0);
        add_entry(sel_data, 1'b0, 32'h044, '0, 32'h1234_5678, 0, 0, 1'b0);
        add_entry(sel_data, 1'b1, 32'h01C, 32'hDEAD_BEEF, '0, 0, 1, 1'b0);
        add_entry(sel_data, 1'b0, 32'h01C, '0, 32'hDEAD_BEEF, 1, 0, 1'b0);
        add_entry(sel_data, 1'b0, 32'h01C, '0, 32'hDEAD_BEEF, 0, 0, 1'b0);
        // icache keeps a stale copy
        add_entry(sel_inst, 1'b0, 32'h044, '0, 32'h1234_5678, 1, 0, 1'b0);
        add_entry(sel_data, 1'b1, 32'h044, 32'hCAFE_F00D, '0, 0, 1, 1'b0);
        add_entry(sel_inst, 1'b0, 32'h044, '0, 32'h1234_5678, 0, 0, 1'b0);
        // same index, different tag
        add_entry(sel_data, 1'b0, 32'h0C4, '0, init_word(32'h0C4), 1, 0, 1'b0);
        add_entry(sel_data, 1'b0, 32'h044, '0, 32'hCAFE_F00D, 1, 0, 1'b0);
        add_entry(sel_data, 1'b0, 32'h0C4, '0, init_word(32'h0C4), 1, 0, 1'b0);
        add_entry(sel_data, 1'b0, 32'h044, '0, 32'hCAFE_F00D, 1, 0, 1'b0);
        // code load through the inst port
        add_entry(sel_inst, 1'b1, 32'h0A0, 32'h0BAD_C0DE, '0, 0, 1, 1'b0);
        add_entry(sel_inst, 1'b0, 32'h0A0, '0, 32'h0BAD_C0DE, 1, 0, 1'b0);
        // both ports at once
        add_entry(sel_inst, 1'b0, 32'h3F0, '0, init_word(32'h3F0), 1, 0, 1'b1);
        add_entry(sel_data, 1'b0, 32'h2E8, '0, init_word(32'h2E8), 1, 0, 1'b0);
        add_entry(sel_inst, 1'b0, 32'h3F0, '0, init_word(32'h3F0), 0, 0, 1'b1);
        add_entry(sel_data, 1'b0, 32'h1E8, '0, init_word(32'h1E8), 1, 0, 1'b0);
    endtask

    // one four-phase operation, entered and left on a falling edge
    task automatic run_op(input logic port, input logic we, input addr_t addr,
                          input data_t wdata, output data_t rdata);
        if (port == sel_inst) begin
            inst_we    = we;
            inst_addr  = addr;
            inst_wdata = wdata;
            inst_req   = 1'b1;
            while (!inst_ack)
                @(negedge aclk);
            rdata    = inst_rdata;
            inst_req = 1'b0;
            while (inst_ack)
                @(negedge aclk);
        end else begin
            data_we    = we;
            data_addr  = addr;
            data_wdata = wdata;
            data_req   = 1'b1;
            while (!data_ack)
                @(negedge aclk);
            rdata    = data_rdata;
            data_req = 1'b0;
            while (data_ack)
                @(negedge aclk);
        end
    endtask

    task automatic check_entry(input int k, input data_t got);
        if (!tbl_we[k]) begin
            check_data($sformatf("entry %0d read data", k), got, tbl_rdata[k]);
        end else begin
            check_addr($sformatf("entry %0d write addr", k), last_wr_addr, tbl_addr[k]);
            check_data($sformatf("entry %0d write data", k), last_wr_data, tbl_wdata[k]);
        end
    endtask

    initial begin : stimulus
        int    i;
        int    k;
        int    n_ops;
        int    rd0;
        int    wr0;
        int    err0;
        data_t got_a;
        data_t got_b;
        n_checks   = 0;
        n_errors   = 0;
        rst_n      = 1'b0;
        inst_req   = 1'b0;
        inst_we    = 1'b0;
        inst_addr  = '0;
        inst_wdata = '0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        load_table();
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        repeat (2) @(negedge aclk);

        check_flag("inst_ack after reset", inst_ack, 1'b0);
        check_flag("data_ack after reset", data_ack, 1'b0);
        check_flag("mem_req after reset", mem_req, 1'b0);
        check_count("external reads after reset", rd_count, 0);
        check_count("external writes after reset", wr_count, 0);
        $display("reset state: %s", (n_errors == 0) ? "ok" : "FAILED");

        i = 0;
        while (i < n_entries) begin
            rd0   = rd_count;
            wr0   = wr_count;
            err0  = n_errors;
            n_ops = tbl_pair[i] ? 2 : 1;
            if (n_ops == 2) begin
                fork
                    run_op(tbl_port[i], tbl_we[i], tbl_addr[i], tbl_wdata[i], got_a);
                    run_op(tbl_port[i+1], tbl_we[i+1], tbl_addr[i+1], tbl_wdata[i+1], got_b);
                join
                check_entry(i, got_a);
                check_entry(i + 1, got_b);
                check_count("external reads", rd_count - rd0, tbl_rd[i] + tbl_rd[i+1]);
                check_count("external writes", wr_count - wr0, tbl_wr[i] + tbl_wr[i+1]);
            end else begin
                run_op(tbl_port[i], tbl_we[i], tbl_addr[i], tbl_wdata[i], got_a);
                check_entry(i, got_a);
                check_count("external reads", rd_count - rd0, tbl_rd[i]);
                check_count("external writes", wr_count - wr0, tbl_wr[i]);
            end
            for (k = i; k < i + n_ops; k++)
                $display("entry %2d %s %-5s addr %h: %s", k,
                         tbl_port[k] ? "data" : "inst", tbl_we[k] ? "write" : "read",
                         tbl_addr[k], (n_errors == err0) ? "ok" : "FAILED");
            i = i + n_ops;
        end

        $display("entries %0d, checks %0d, errors %0d", n_entries, n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // generous bound, 80 cycles per entry
    initial begin : watchdog
        cache_state_e ic_st;
        cache_state_e dc_st;
        grant_e       owner;
        #(n_entries * 80 * clk_period);
        ic_st = dut0.icache.state;
        dc_st = dut0.dcache.state;
        owner = dut0.arb.grant;
        $display("timeout: handshake hung after %0d cycles, icache %s, dcache %s, owner %s",
                 n_entries * 80, ic_st.name(), dc_st.name(), owner.name());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mem_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_responder
    import mem_types_pkg::*;
#(
    parameter data_t       init_base = 32'hC0DE_0000,
    parameter int unsigned seed      = 39550
) (
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  mem_req,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  data_t mem_wdata,
    output logic  mem_ack,
    output data_t mem_rdata,
    output int    rd_count,
    output int    wr_count,
    output addr_t last_wr_addr,
    output data_t last_wr_data
);

    data_t       mem [256];
    logic [31:0] rng_state;
    logic [7:0]  word;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = init_base + i;     // word index plus offset
        rng_state    = seed;
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        rd_count     = 0;
        wr_count     = 0;
        last_wr_addr = '0;
        last_wr_data = '0;
        forever begin
            @(negedge aclk);
            if (rst_n && mem_req && !mem_ack) begin
                rng_state = xorshift32(rng_state);
                repeat (rng_state % 4)
                    @(negedge aclk);    // 0 to 3 cycles of wait
                word = mem_addr[9:2];
                if (mem_we) begin
                    mem[word]    = mem_wdata;
                    wr_count     = wr_count + 1;
                    last_wr_addr = mem_addr;
                    last_wr_data = mem_wdata;
                end else begin
                    mem_rdata = mem[word];
                    rd_count  = rd_count + 1;
                end
                mem_ack = 1'b1;
                while (mem_req)
                    @(negedge aclk);
                mem_ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsys_top
    import mem_types_pkg::*;
(
    input  logic  aclk,
    input  logic  rst_n,
    // instruction fetch
    input  logic  inst_req,
    input  logic  inst_we,
    input  addr_t inst_addr,
    input  data_t inst_wdata,
    output logic  inst_ack,
    output data_t inst_rdata,
    // load/store
    input  logic  data_req,
    input  logic  data_we,
    input  addr_t data_addr,
    input  data_t data_wdata,
    output logic  data_ack,
    output data_t data_rdata,
    // shared external memory
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_wdata,
    input  logic  mem_ack,
    input  data_t mem_rdata
);

    // icache <-> arbiter
    logic  ic_bus_req;
    logic  ic_bus_we;
    addr_t ic_bus_addr;
    data_t ic_bus_wdata;
    logic  ic_bus_ack;
    data_t ic_bus_rdata;

    // dcache <-> arbiter
    logic  dc_bus_req;
    logic  dc_bus_we;
    addr_t dc_bus_addr;
    data_t dc_bus_wdata;
    logic  dc_bus_ack;
    data_t dc_bus_rdata;

    line_cache icache (
        .aclk      (aclk        ),
        .rst_n     (rst_n       ),
        .cpu_req   (inst_req    ),
        .cpu_we    (inst_we     ),  // only used for loading code
        .cpu_addr  (inst_addr   ),
        .cpu_wdata (inst_wdata  ),
        .cpu_ack   (inst_ack    ),
        .cpu_rdata (inst_rdata  ),
        .bus_req   (ic_bus_req  ),
        .bus_we    (ic_bus_we   ),
        .bus_addr  (ic_bus_addr ),
        .bus_wdata (ic_bus_wdata),
        .bus_ack   (ic_bus_ack  ),
        .bus_rdata (ic_bus_rdata)
    );

    line_cache dcache (
        .aclk      (aclk        ),
        .rst_n     (rst_n       ),
        .cpu_req   (data_req    ),
        .cpu_we    (data_we     ),
        .cpu_addr  (data_addr   ),
        .cpu_wdata (data_wdata  ),
        .cpu_ack   (data_ack    ),
        .cpu_rdata (data_rdata  ),
        .bus_req   (dc_bus_req  ),
        .bus_we    (dc_bus_we   ),
        .bus_addr  (dc_bus_addr ),
        .bus_wdata (dc_bus_wdata),
        .bus_ack   (dc_bus_ack  ),
        .bus_rdata (dc_bus_rdata)
    );

    bus_arbiter arb (
        .aclk        (aclk        ),
        .rst_n       (rst_n       ),
        .i_bus_req   (ic_bus_req  ),
        .i_bus_we    (ic_bus_we   ),
        .i_bus_addr  (ic_bus_addr ),
        .i_bus_wdata (ic_bus_wdata),
        .i_bus_ack   (ic_bus_ack  ),
        .i_bus_rdata (ic_bus_rdata),
        .d_bus_req   (dc_bus_req  ),
        .d_bus_we    (dc_bus_we   ),
        .d_bus_addr  (dc_bus_addr ),
        .d_bus_wdata (dc_bus_wdata),
        .d_bus_ack   (dc_bus_ack  ),
        .d_bus_rdata (dc_bus_rdata),
        .mem_req     (mem_req     ),
        .mem_we      (mem_we      ),
        .mem_addr    (mem_addr    ),
        .mem_wdata   (mem_wdata   ),
        .mem_ack     (mem_ack     ),
        .mem_rdata   (mem_rdata   )
    );

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module bus_arbiter
    import mem_types_pkg::*;
    import bus_pkg::*;
(
    input  logic  aclk,
    input  logic  rst_n,
    // icache port
    input  logic  i_bus_req,
    input  logic  i_bus_we,
    input  addr_t i_bus_addr,
    input  data_t i_bus_wdata,
    output logic  i_bus_ack,
    output data_t i_bus_rdata,
    // dcache port
    input  logic  d_bus_req,
    input  logic  d_bus_we,
    input  addr_t d_bus_addr,
    input  data_t d_bus_wdata,
    output logic  d_bus_ack,
    output data_t d_bus_rdata,
    // external memory
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_wdata,
    input  logic  mem_ack,
    input  data_t mem_rdata
);

    arb_state_e state;
    grant_e     grant;
    grant_e     last_q;     // last cache served
    grant_e     pick;
    logic       sel_req;
    data_t      rdata_q;

    // round robin when both wait
    always_comb begin
        if (i_bus_req && d_bus_req)
            pick = (last_q == G_INST) ? G_DATA : G_INST;
        else if (i_bus_req)
            pick = G_INST;
        else if (d_bus_req)
            pick = G_DATA;
        else
            pick = G_NONE;
    end

    assign sel_req = (grant == G_INST) ? i_bus_req :
                     (grant == G_DATA) ? d_bus_req : 1'b0;

    // read data only reaches the owner
    assign i_bus_rdata = (grant == G_INST) ? rdata_q : '0;
    assign d_bus_rdata = (grant == G_DATA) ? rdata_q : '0;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= A_IDLE;
            grant     <= G_NONE;
            last_q    <= G_DATA;    // icache wins the first tie
            mem_req   <= 1'b0;
            i_bus_ack <= 1'b0;
            d_bus_ack <= 1'b0;
        end else begin
            // ack trails mem_ack by one cycle
            i_bus_ack <= (grant == G_INST) && mem_ack;
            d_bus_ack <= (grant == G_DATA) && mem_ack;
            case (state)
                A_IDLE: begin
                    if (pick != G_NONE) begin
                        grant   <= pick;
                        last_q  <= pick;
                        mem_req <= 1'b1;
                        state   <= A_BUSY;
                    end
                end
                A_BUSY: begin
                    mem_req <= sel_req;
                    if (!sel_req)
                        state <= A_REL;
                end
                A_REL: begin
                    if (!sel_req && !mem_ack) begin
                        grant <= G_NONE;
                        state <= A_IDLE;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == A_IDLE && pick != G_NONE) begin
            mem_we    <= (pick == G_INST) ? i_bus_we    : d_bus_we;
            mem_addr  <= (pick == G_INST) ? i_bus_addr  : d_bus_addr;
            mem_wdata <= (pick == G_INST) ? i_bus_wdata : d_bus_wdata;
        end
        if (mem_ack)
            rdata_q <= mem_rdata;
    end

    a_no_stray_ack: assert property (
        @(posedge aclk) disable iff (!rst_n)
        !((grant != G_INST) && i_bus_ack) && !((grant != G_DATA) && d_bus_ack)
    ) else $error("ack seen by a cache that does not own the memory port");

endmodule

`default_nettype wire

// ==== design/line_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module line_cache
    import mem_types_pkg::*;
(
    input  logic  aclk,
    input  logic  rst_n,
    // processor side
    input  logic  cpu_req,
    input  logic  cpu_we,
    input  addr_t cpu_addr,
    input  data_t cpu_wdata,
    output logic  cpu_ack,
    output data_t cpu_rdata,
    // towards the arbiter
    output logic  bus_req,
    output logic  bus_we,
    output addr_t bus_addr,
    output data_t bus_wdata,
    input  logic  bus_ack,
    input  data_t bus_rdata
);

    cache_state_e state;

    tag_t  tag_arr  [`CACHE_SETS];
    data_t data_arr [`CACHE_SETS];
    logic  [`CACHE_SETS-1:0] valid_arr;

    index_t idx;
    tag_t   tag_in;
    logic   lookup_hit;
    logic   hit_q;      // hit result kept for the write update

    // addr[1:0] is a byte offset and plays no part here
    assign idx    = cpu_addr[`INDEX_W+1:2];
    assign tag_in = cpu_addr[`ADDR_W-1:`ADDR_W-`TAG_W];

    assign lookup_hit = valid_arr[idx] && (tag_arr[idx] == tag_in);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= C_IDLE;
            cpu_ack   <= 1'b0;
            bus_req   <= 1'b0;
            hit_q     <= 1'b0;
            valid_arr <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (cpu_req)
                        state <= C_LOOKUP;
                end
                C_LOOKUP: begin
                    hit_q <= lookup_hit;
                    if (lookup_hit && !cpu_we) begin
                        state <= C_RESP;    // read hit
                    end else begin
                        bus_req <= 1'b1;    // read miss or write through
                        state   <= C_BUS;
                    end
                end
                C_BUS: begin
                    if (bus_ack) begin
                        bus_req <= 1'b0;
                        state   <= C_BUS_REL;
                    end
                end
                C_BUS_REL: begin
                    if (!bus_ack) begin
                        if (!cpu_we)
                            valid_arr[idx] <= 1'b1;     // fill on read miss
                        state <= C_RESP;
                    end
                end
                C_RESP: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // arrays and bus payload
    always_ff @(posedge aclk) begin
        case (state)
            C_LOOKUP: begin
                cpu_rdata <= data_arr[idx];
                bus_we    <= cpu_we;
                bus_addr  <= cpu_addr;
                bus_wdata <= cpu_wdata;
            end
            C_BUS: begin
                if (bus_ack && !cpu_we)
                    cpu_rdata <= bus_rdata;
            end
            C_BUS_REL: begin
                if (!bus_ack) begin
                    if (!cpu_we) begin
                        tag_arr[idx]  <= tag_in;
                        data_arr[idx] <= cpu_rdata;
                    end else if (hit_q) begin
                        data_arr[idx] <= cpu_wdata; // no allocate on write miss
                    end
                end
            end
            default: ;
        endcase
    end

    // the arbiter must have finished the previous handshake
    a_bus_req_after_ack: assert property (
        @(posedge aclk) disable iff (!rst_n)
        $rose(bus_req) |-> !bus_ack
    ) else $error("bus_req rose while bus_ack still high");

    // lookup and line update both read cpu_addr directly
    a_cpu_addr_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        cpu_req && $past(cpu_req) |-> $stable(cpu_addr)
    ) else $error("cpu_addr changed during a request");

endmodule

`default_nettype wire

// ==== design/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // owner of the shared memory port
    typedef enum logic [1:0] {
        G_NONE,
        G_INST,
        G_DATA
    } grant_e;

    typedef enum logic [1:0] {
        A_IDLE,
        A_BUSY,
        A_REL   // owner req down, waiting on mem_ack
    } arb_state_e;

endpackage

`default_nettype wire

// ==== design/mem_types_pkg.sv ====
`default_nettype none

`include "mem_params.svh"

package mem_types_pkg;

    typedef logic [`ADDR_W-1:0]  addr_t;
    typedef logic [`DATA_W-1:0]  data_t;
    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`INDEX_W-1:0] index_t;

    // line_cache FSM
    typedef enum logic [2:0] {
        C_IDLE,
        C_LOOKUP,
        C_BUS,      // bus_req up, waiting for ack
        C_BUS_REL,  // waiting for bus_ack to fall
        C_RESP
    } cache_state_e;

endpackage

`default_nettype wire

// ==== design/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// bus widths
`define ADDR_W     32
`define DATA_W     32

// one word per line
`define CACHE_SETS 16
`define INDEX_W    4    // index is addr[5:2]
`define TAG_W      26   // addr[31:6]

`endif
